// ==== logic/branch_exec_defs.svh ====
`ifndef BRANCH_EXEC_DEFS_SVH
`define BRANCH_EXEC_DEFS_SVH

// Operand, address and result width
`define BE_XLEN 32

// Destination register index width
`define BE_REG_ADDR_W 5

// Queue depths as powers of two
`define BE_ISSUE_DEPTH 4
`define BE_RESULT_DEPTH 4

`endif

// ==== logic/branch_exec_pkg.sv ====
`include "branch_exec_defs.svh"

package branch_exec_pkg;

    // Commands known to the compare unit
    // Any code outside this list is reported as illegal
    typedef enum logic [3:0] {
        c_SLT  = 4'h0,
        c_SLTU = 4'h1,
        c_BEQ  = 4'h2,
        c_BNE  = 4'h3,
        c_BGE  = 4'h4,
        c_BLT  = 4'h5,
        c_BGEU = 4'h6,
        c_BLTU = 4'h7
    } alu_cmd_t;

    // One issue record as written by the issuer
    typedef struct packed {
        alu_cmd_t                    cmd;
        logic [`BE_XLEN-1:0]         arg0;
        logic [`BE_XLEN-1:0]         arg1;
        logic [`BE_XLEN-1:0]         addr;
        logic [`BE_XLEN-1:0]         imm;
        logic [`BE_REG_ADDR_W-1:0]   rd;
    } issue_t;

    // One result record as seen by the committer
    typedef struct packed {
        // Branch target or set bit
        logic [`BE_XLEN-1:0]         res;
        logic [`BE_REG_ADDR_W-1:0]   rd;
        logic                        taken;
        // Carry out of addr + imm
        logic                        overflow;
        logic                        illegal;
    } result_t;

endpackage

// ==== logic/record_fifo.sv ====
`timescale 1ns/1ps

`include "branch_exec_defs.svh"

module record_fifo #(
    parameter type T     = logic [7:0],
    parameter int  DEPTH = `BE_ISSUE_DEPTH
) (
    input  logic    clk,
    input  logic    rst_n,

    // Write side
    input  logic    i_valid,
    input  T        i_data,
    output logic    o_ready,

    // Read side with the head shown combinationally
    output logic    o_valid,
    output T        o_data,
    input  logic    i_ready
);

    localparam int AW = $clog2(DEPTH);

    T               mem [DEPTH];
    logic [AW-1:0]  wr_ptr;
    logic [AW-1:0]  rd_ptr;
    logic [AW:0]    count;
    logic           full;
    logic           empty;
    logic           push;
    logic           pop;

    assign full  = (count == (AW+1)'(DEPTH));
    assign empty = (count == '0);

    // A pop in the same cycle frees the slot for a write when full
    assign o_ready = !full || i_ready;
    assign o_valid = !empty;
    assign o_data  = mem[rd_ptr];

    assign push = i_valid && o_ready;
    assign pop  = i_ready && o_valid;

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= i_data;
        end
    end

    // Pointers wrap naturally for power of two depths
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

// ==== logic/wb_issue_slave.sv ====
`timescale 1ns/1ps

`include "branch_exec_defs.svh"

module wb_issue_slave
    import branch_exec_pkg::*;
(
    input  logic    clk,
    input  logic    rst_n,

    // Write-only Wishbone classic slave
    input  logic    i_wb_cyc,
    input  logic    i_wb_stb,
    input  logic    i_wb_we,
    input  issue_t  i_wb_dat,
    output logic    o_wb_ack,

    // Push side of the issue queue
    output logic    o_push_valid,
    output issue_t  o_push_data,
    input  logic    i_push_ready
);

    logic   accept;
    issue_t push_data_q;

    // New write request while the queue has room
    // The previous ack must be low so each cycle is acked once
    assign accept = i_wb_cyc && i_wb_stb && i_wb_we && i_push_ready && !o_wb_ack;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            o_wb_ack <= 1'b0;
        end else begin
            o_wb_ack <= accept;
        end
    end

    // Capture while the master still holds the data
    always_ff @(posedge clk) begin
        if (accept) begin
            push_data_q <= i_wb_dat;
        end
    end

    // Push coincides with the ack cycle
    assign o_push_valid = o_wb_ack;
    assign o_push_data  = push_data_q;

endmodule

// ==== logic/cmp_branch_unit.sv ====
`timescale 1ns/1ps

`include "branch_exec_defs.svh"

module cmp_branch_unit
    import branch_exec_pkg::*;
(
    input  logic    clk,
    input  logic    rst_n,

    // From the issue queue
    input  logic    i_valid,
    input  issue_t  i_issue,
    output logic    o_ready,

    // To the result queue
    output logic    o_valid,
    output result_t o_result,
    input  logic    i_ready
);

    logic [`BE_XLEN:0] target;
    logic              eq;
    logic              lt_s;
    logic              lt_u;
    logic              is_branch;
    logic              cond;
    result_t           result_d;
    logic              accept;

    // Shared comparators for set and branch commands
    assign eq   = (i_issue.arg0 == i_issue.arg1);
    assign lt_s = ($signed(i_issue.arg0) < $signed(i_issue.arg1));
    assign lt_u = (i_issue.arg0 < i_issue.arg1);

    // One extra bit keeps the carry out
    assign target = {1'b0, i_issue.addr} + {1'b0, i_issue.imm};

    always_comb begin
        result_d    = '0;
        result_d.rd = i_issue.rd;
        is_branch   = 1'b0;
        cond        = 1'b0;

        case (i_issue.cmd)
            c_SLT: begin
                result_d.res = {{(`BE_XLEN-1){1'b0}}, lt_s};
            end
            c_SLTU: begin
                result_d.res = {{(`BE_XLEN-1){1'b0}}, lt_u};
            end
            c_BEQ: begin
                is_branch = 1'b1;
                cond      = eq;
            end
            c_BNE: begin
                is_branch = 1'b1;
                cond      = !eq;
            end
            c_BGE: begin
                is_branch = 1'b1;
                cond      = !lt_s;
            end
            c_BLT: begin
                is_branch = 1'b1;
                cond      = lt_s;
            end
            c_BGEU: begin
                is_branch = 1'b1;
                cond      = !lt_u;
            end
            c_BLTU: begin
                is_branch = 1'b1;
                cond      = lt_u;
            end
            default: begin
                // Only rd survives an unknown command
                result_d.illegal = 1'b1;
            end
        endcase

        if (is_branch) begin
            result_d.res      = target[`BE_XLEN-1:0];
            result_d.overflow = target[`BE_XLEN];
            result_d.taken    = cond;
        end
    end

    // Take a new item when the output register is free or draining
    assign o_ready = !o_valid || i_ready;
    assign accept  = i_valid && o_ready;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            o_valid <= 1'b0;
        end else if (accept) begin
            o_valid <= 1'b1;
        end else if (i_ready) begin
            o_valid <= 1'b0;
        end
    end

    // Held while the result queue is full
    always_ff @(posedge clk) begin
        if (accept) begin
            o_result <= result_d;
        end
    end

endmodule

// ==== logic/wb_commit_master.sv ====
`timescale 1ns/1ps

`include "branch_exec_defs.svh"

module wb_commit_master
    import branch_exec_pkg::*;
(
    input  logic    clk,
    input  logic    rst_n,

    // Head of the result queue
    input  logic    i_valid,
    input  result_t i_result,
    output logic    o_ready,

    // Write-only Wishbone classic master
    output logic    o_wb_cyc,
    output logic    o_wb_stb,
    output logic    o_wb_we,
    output result_t o_wb_dat,
    input  logic    i_wb_ack
);

    typedef enum logic {
        ST_IDLE,
        ST_WRITE
    } state_t;

    state_t state;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= ST_IDLE;
        end else begin
            case (state)
                ST_IDLE:  if (i_valid) state <= ST_WRITE;
                ST_WRITE: if (i_wb_ack) state <= ST_IDLE;
                default:  state <= ST_IDLE;
            endcase
        end
    end

    // Head is latched when the write cycle opens
    always_ff @(posedge clk) begin
        if (state == ST_IDLE && i_valid) begin
            o_wb_dat <= i_result;
        end
    end

    // Going back through idle leaves stb low one cycle between items
    assign o_wb_cyc = (state == ST_WRITE);
    assign o_wb_stb = (state == ST_WRITE);
    assign o_wb_we  = (state == ST_WRITE);

    // Pop on the acked cycle
    assign o_ready = (state == ST_WRITE) && i_wb_ack;

endmodule

// ==== logic/branch_exec.sv ====
`timescale 1ns/1ps

`include "branch_exec_defs.svh"

module branch_exec
    import branch_exec_pkg::*;
(
    input  logic    clk,
    input  logic    rst_n,

    // Issuer bus
    input  logic    i_wb_cyc,
    input  logic    i_wb_stb,
    input  logic    i_wb_we,
    input  issue_t  i_wb_dat,
    output logic    o_wb_ack,

    // Committer bus
    output logic    o_wb_cyc,
    output logic    o_wb_stb,
    output logic    o_wb_we,
    output result_t o_wb_dat,
    input  logic    i_wb_ack
);

    // Slave to issue queue
    logic    iss_push_valid;
    issue_t  iss_push_data;
    logic    iss_push_ready;

    // Issue queue to compare unit
    logic    iss_pop_valid;
    issue_t  iss_pop_data;
    logic    iss_pop_ready;

    // Compare unit to result queue
    logic    res_push_valid;
    result_t res_push_data;
    logic    res_push_ready;

    // Result queue to commit master
    logic    res_pop_valid;
    result_t res_pop_data;
    logic    res_pop_ready;

    wb_issue_slave u_wb_issue_slave (
        .clk          (clk),
        .rst_n        (rst_n),
        .i_wb_cyc     (i_wb_cyc),
        .i_wb_stb     (i_wb_stb),
        .i_wb_we      (i_wb_we),
        .i_wb_dat     (i_wb_dat),
        .o_wb_ack     (o_wb_ack),
        .o_push_valid (iss_push_valid),
        .o_push_data  (iss_push_data),
        .i_push_ready (iss_push_ready)
    );

    record_fifo #(
        .T     (issue_t),
        .DEPTH (`BE_ISSUE_DEPTH)
    ) u_issue_fifo (
        .clk     (clk),
        .rst_n   (rst_n),
        .i_valid (iss_push_valid),
        .i_data  (iss_push_data),
        .o_ready (iss_push_ready),
        .o_valid (iss_pop_valid),
        .o_data  (iss_pop_data),
        .i_ready (iss_pop_ready)
    );

    cmp_branch_unit u_cmp_branch_unit (
        .clk      (clk),
        .rst_n    (rst_n),
        .i_valid  (iss_pop_valid),
        .i_issue  (iss_pop_data),
        .o_ready  (iss_pop_ready),
        .o_valid  (res_push_valid),
        .o_result (res_push_data),
        .i_ready  (res_push_ready)
    );

    record_fifo #(
        .T     (result_t),
        .DEPTH (`BE_RESULT_DEPTH)
    ) u_result_fifo (
        .clk     (clk),
        .rst_n   (rst_n),
        .i_valid (res_push_valid),
        .i_data  (res_push_data),
        .o_ready (res_push_ready),
        .o_valid (res_pop_valid),
        .o_data  (res_pop_data),
        .i_ready (res_pop_ready)
    );

    wb_commit_master u_wb_commit_master (
        .clk      (clk),
        .rst_n    (rst_n),
        .i_valid  (res_pop_valid),
        .i_result (res_pop_data),
        .o_ready  (res_pop_ready),
        .o_wb_cyc (o_wb_cyc),
        .o_wb_stb (o_wb_stb),
        .o_wb_we  (o_wb_we),
        .o_wb_dat (o_wb_dat),
        .i_wb_ack (i_wb_ack)
    );

endmodule

// ==== bench/branch_exec_tests.svh ====
// Both orders of one pair through SLT and SLTU
task automatic issue_set_pair(input logic [`BE_XLEN-1:0] x, input logic [`BE_XLEN-1:0] y);
    issue_record(c_SLT, x, y, 32'h0000_0100, 32'h0000_0004);
    issue_record(c_SLT, y, x, 32'h0000_0100, 32'h0000_0004);
    issue_record(c_SLTU, x, y, 32'hffff_ffff, 32'h0000_0001);
    issue_record(c_SLTU, y, x, 32'hffff_ffff, 32'h0000_0001);
endtask

task automatic test_set_compare();
    int err_start;
    err_start = errors;
    ack_delay = 0;
    issue_set_pair(32'd5, 32'd5);
    issue_set_pair(32'h8000_0000, 32'd1);
    issue_set_pair(32'hffff_ffff, 32'd1);
    end_test("set compare", err_start);
endtask

// Equal, less, and mixed sign pairs make every condition true and false
task automatic test_branches();
    int err_start;
    int c;
    err_start = errors;
    ack_delay = 2;
    for (c = c_BEQ; c <= c_BLTU; c++) begin
        issue_record(4'(c), 32'd7, 32'd7, 32'h0000_1000, 32'h0000_0020);
        issue_record(4'(c), 32'd7, 32'd9, 32'h0000_2000, 32'hffff_fff0);
        issue_record(4'(c), 32'hffff_ffff, 32'd1, 32'hffff_ffff, 32'd1);
        issue_record(4'(c), 32'd1, 32'hffff_ffff, 32'h8000_0000, 32'h8000_0000);
    end
    end_test("branch conditions", err_start);
endtask

task automatic test_illegal();
    int err_start;
    int c;
    err_start = errors;
    ack_delay = 1;
    for (c = 8; c < 16; c++) begin
        issue_record(4'(c), 32'h1234, 32'h1234, 32'hffff_ffff, 32'd1);
    end
    end_test("illegal commands", err_start);
endtask

task automatic test_backpressure();
    int     err_start;
    int     accepted;
    int     i;
    bit     acked;
    issue_t rec;
    err_start = errors;
    accepted = 0;
    acked = 1'b1;
    ack_delay = 0;
    hold_ack = 1'b1;
    // Both queues plus the compare register fill, then acks stop
    for (i = 0; i < 16 && acked; i++) begin
        rec = '0;
        rec.cmd  = c_BNE;
        rec.arg0 = i;
        rec.arg1 = 32'd3;
        rec.addr = 32'h1000 + 4 * i;
        rec.imm  = 32'h40;
        rec.rd   = rd_seq[`BE_REG_ADDR_W-1:0];
        rd_seq++;
        drive_issue(rec);
        wait_issue_ack(40, acked);
        if (acked) begin
            accepted++;
        end
    end
    assert (!acked && accepted >= `BE_ISSUE_DEPTH + `BE_RESULT_DEPTH) else begin
        $display("Issue acks did not stop under back-pressure, %0d accepted", accepted);
        errors++;
    end
    hold_ack = 1'b0;
    // The stalled write is still on the bus
    wait_issue_ack(HOLD_LIMIT, acked);
    assert (acked) else begin
        $display("Issue acks did not resume after the committer released ack");
        errors++;
        idle_bus();
    end
    for (i = 0; i < 4; i++) begin
        issue_record(c_BEQ, i, 32'd2, 32'h2000 + 4 * i, 32'h10);
    end
    end_test("back-pressure", err_start);
endtask

task automatic test_random_mix();
    int                  err_start;
    int                  i;
    logic [`BE_XLEN-1:0] a;
    logic [`BE_XLEN-1:0] b;
    err_start = errors;
    for (i = 0; i < 200; i++) begin
        ack_delay = $urandom_range(0, 6);
        rd_seq = $urandom();
        a = $urandom();
        // Equal operands now and then so BEQ and BGE take
        b = ($urandom_range(0, 3) == 0) ? a : $urandom();
        issue_record(4'($urandom_range(0, 15)), a, b, $urandom(), $urandom());
    end
    wait_drain();
    check_field("committed count", issued, committed);
    end_test("random mix", err_start);
endtask

// ==== bench/branch_exec_tb.sv ====
`timescale 1ns/1ps

`include "branch_exec_defs.svh"

module branch_exec_tb
    import branch_exec_pkg::*;
();

    localparam int ACK_LIMIT   = 64;
    localparam int HOLD_LIMIT  = 2000;
    localparam int DRAIN_LIMIT = 4000;

    logic    clk;
    logic    rst_n;
    logic    wb_cyc;
    logic    wb_stb;
    logic    wb_we;
    issue_t  wb_dat;
    logic    wb_ack;
    logic    cm_cyc;
    logic    cm_stb;
    logic    cm_we;
    result_t cm_dat;
    logic    cm_ack;

    int      errors;
    int      issued;
    int      committed;
    int      tests_passed;
    int      tests_failed;
    int      ack_delay;
    int      rd_seq;
    bit      hold_ack;
    result_t exp_q [$];

    branch_exec i_branch_exec (
        .clk      (clk),
        .rst_n    (rst_n),
        .i_wb_cyc (wb_cyc),
        .i_wb_stb (wb_stb),
        .i_wb_we  (wb_we),
        .i_wb_dat (wb_dat),
        .o_wb_ack (wb_ack),
        .o_wb_cyc (cm_cyc),
        .o_wb_stb (cm_stb),
        .o_wb_we  (cm_we),
        .o_wb_dat (cm_dat),
        .i_wb_ack (cm_ack)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // Expected result straight from the command rules
    function automatic result_t expect_result(input issue_t r);
        result_t                    e;
        logic [`BE_XLEN:0]          sum;
        logic signed [`BE_XLEN-1:0] sa;
        logic signed [`BE_XLEN-1:0] sb;
        e = '0;
        e.rd = r.rd;
        sum = r.addr + r.imm;
        sa = r.arg0;
        sb = r.arg1;
        case (r.cmd)
            c_SLT:   e.res = (sa < sb);
            c_SLTU:  e.res = (r.arg0 < r.arg1);
            c_BEQ:   e.taken = (r.arg0 == r.arg1);
            c_BNE:   e.taken = (r.arg0 != r.arg1);
            c_BGE:   e.taken = (sa >= sb);
            c_BLT:   e.taken = (sa < sb);
            c_BGEU:  e.taken = (r.arg0 >= r.arg1);
            c_BLTU:  e.taken = (r.arg0 < r.arg1);
            default: e.illegal = 1'b1;
        endcase
        // Branches carry the target and its carry out
        if (!e.illegal && r.cmd != c_SLT && r.cmd != c_SLTU) begin
            e.res = sum[`BE_XLEN-1:0];
            e.overflow = sum[`BE_XLEN];
        end
        return e;
    endfunction

    task automatic check_field(input string name, input logic [`BE_XLEN-1:0] exp,
                               input logic [`BE_XLEN-1:0] act);
        assert (exp === act) else begin
            $display("Error at %0t ns: %s expected 0x%0h, got 0x%0h", $time, name, exp, act);
            errors++;
        end
    endtask

    task automatic check_commit(input result_t act);
        result_t exp;
        if (exp_q.size() == 0) begin
            $display("Commit at %0t ns arrived with no issued record left to match", $time);
            errors++;
        end else begin
            exp = exp_q.pop_front();
            check_field("o_wb_cyc", 1'b1, cm_cyc);
            check_field("o_wb_we", 1'b1, cm_we);
            check_field("res", exp.res, act.res);
            check_field("rd", exp.rd, act.rd);
            check_field("taken", exp.taken, act.taken);
            check_field("overflow", exp.overflow, act.overflow);
            check_field("illegal", exp.illegal, act.illegal);
            committed++;
        end
    endtask

    // Committer model acks each write after ack_delay cycles or once released
    initial begin : committer
        int n;
        cm_ack = 1'b0;
        forever begin
            @(negedge clk);
            if (cm_stb) begin
                n = 0;
                while ((n < ack_delay || hold_ack) && n < HOLD_LIMIT) begin
                    @(negedge clk);
                    n++;
                end
                if (n >= HOLD_LIMIT) begin
                    $display("Committer gave up holding ack at %0t ns", $time);
                    errors++;
                end
                check_commit(cm_dat);
                cm_ack = 1'b1;
                @(negedge clk);
                cm_ack = 1'b0;
            end
        end
    end

    task automatic idle_bus();
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we  = 1'b0;
    endtask

    task automatic drive_issue(input issue_t rec);
        @(negedge clk);
        wb_cyc = 1'b1;
        wb_stb = 1'b1;
        wb_we  = 1'b1;
        wb_dat = rec;
        exp_q.push_back(expect_result(rec));
    endtask

    // Bus is released after the edge that sees ack
    task automatic wait_issue_ack(input int limit, output bit acked);
        int n;
        acked = 1'b0;
        for (n = 0; n < limit && !acked; n++) begin
            @(negedge clk);
            acked = wb_ack;
        end
        if (acked) begin
            issued++;
            @(negedge clk);
            idle_bus();
        end
    endtask

    task automatic issue_record(input logic [3:0] cmd, input logic [`BE_XLEN-1:0] arg0,
                                input logic [`BE_XLEN-1:0] arg1,
                                input logic [`BE_XLEN-1:0] addr,
                                input logic [`BE_XLEN-1:0] imm);
        issue_t rec;
        bit     acked;
        rec.cmd  = alu_cmd_t'(cmd);
        rec.arg0 = arg0;
        rec.arg1 = arg1;
        rec.addr = addr;
        rec.imm  = imm;
        rec.rd   = rd_seq[`BE_REG_ADDR_W-1:0];
        rd_seq++;
        drive_issue(rec);
        wait_issue_ack(ACK_LIMIT, acked);
        if (!acked) begin
            $display("Issue write at %0t ns got no ack", $time);
            errors++;
            idle_bus();
        end
    endtask

    task automatic wait_drain();
        int n;
        n = 0;
        while ((exp_q.size() != 0 || cm_stb) && n < DRAIN_LIMIT) begin
            @(negedge clk);
            n++;
        end
        if (n >= DRAIN_LIMIT) begin
            $display("Timed out waiting for commits, %0d results missing", exp_q.size());
            errors++;
        end
    endtask

    task automatic end_test(input string name, input int err_start);
        wait_drain();
        if (errors == err_start) begin
            tests_passed++;
            $display("%s: passed", name);
        end else begin
            tests_failed++;
            $display("%s: failed with %0d errors", name, errors - err_start);
        end
    endtask

    `include "branch_exec_tests.svh"

    initial begin
        void'($urandom(32'h676d));
        rst_n = 1'b0;
        wb_dat = '0;
        idle_bus();
        errors = 0;
        issued = 0;
        committed = 0;
        tests_passed = 0;
        tests_failed = 0;
        ack_delay = 0;
        rd_seq = 1;
        hold_ack = 1'b0;
        repeat (16) @(negedge clk);
        check_field("o_wb_ack", 1'b0, wb_ack);
        check_field("o_wb_cyc", 1'b0, cm_cyc);
        check_field("o_wb_stb", 1'b0, cm_stb);
        rst_n = 1'b1;
        @(negedge clk);

        test_set_compare();
        test_branches();
        test_illegal();
        test_backpressure();
        test_random_mix();

        $display("Tests passed: %0d, failed: %0d, records issued: %0d, committed: %0d",
                 tests_passed, tests_failed, issued, committed);
        if (errors == 0 && tests_failed == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

// ==== branch_exec.f ====
+incdir+logic
+incdir+bench
logic/branch_exec_pkg.sv
logic/record_fifo.sv
logic/wb_issue_slave.sv
logic/cmp_branch_unit.sv
logic/wb_commit_master.sv
logic/branch_exec.sv
bench/branch_exec_tb.sv
